//--- fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// fetch front end sizing

// first instruction fetched after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// address and data width of the read channel
`define FETCH_XLEN 64

// instruction queue entries, must be a power of two
`define FETCH_QUEUE_DEPTH 4

// log2 of the queue depth
`define FETCH_QUEUE_AW 2

`endif

//--- fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // redirect request from a later stage
    // any flag set is a one-cycle strobe
    typedef struct packed {
        logic                   jal;
        logic                   branch_taken;
        logic                   jalr;
        logic                   trap;
        // pc of the jump or branch itself
        logic [`FETCH_XLEN-1:0] base_pc;
        logic [`FETCH_XLEN-1:0] imm;
        // jalr base register value
        logic [`FETCH_XLEN-1:0] rs1_data;
        logic [`FETCH_XLEN-1:0] mtvec;
    } redirect_t;

    // one fetched instruction with its pc
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] pc;
        logic [31:0]            inst;
    } fetch_entry_t;

endpackage

//--- rv_inst_pkg.sv
package rv_inst_pkg;

    // base opcodes, bits 6:0
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        CLASS_ALU,
        CLASS_ALU_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_SYSTEM,
        CLASS_ILLEGAL
    } inst_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    // branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // same 32 bits, one view per format
    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
        i_type_t     i;
        s_type_t     s;
        b_type_t     b;
        u_type_t     u;
        j_type_t     j;
    } rv_inst_u;

endpackage

//--- pc_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_fetch (
    input  logic                   clk,
    input  logic                   reset_i,
    input  fetch_pkg::redirect_t   redirect_i,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output logic [`FETCH_XLEN-1:0] ar_addr_o,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  logic [`FETCH_XLEN-1:0] r_data_i,
    input  logic                   q_full_i,
    output logic                   q_push_o,
    output fetch_pkg::fetch_entry_t q_entry_o,
    output logic                   q_flush_o
);

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] pc_d;
    logic [`FETCH_XLEN-1:0] ar_addr_q;
    logic [`FETCH_XLEN-1:0] target;
    logic [`FETCH_XLEN-1:0] jalr_sum;
    logic                   ar_valid_q;
    logic                   r_wait_q;
    logic                   stale_q;
    logic                   push_q;
    logic                   redirect_hit;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   push_now;
    logic                   issue;

    assign redirect_hit = redirect_i.jal | redirect_i.branch_taken |
                          redirect_i.jalr | redirect_i.trap;
    assign jalr_sum = redirect_i.rs1_data + redirect_i.imm;

    // jal/branch beat jalr, jalr beats trap
    always_comb begin
        if (redirect_i.jal || redirect_i.branch_taken) begin
            target = redirect_i.base_pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            target = {jalr_sum[`FETCH_XLEN-1:1], 1'b0};
        end else begin
            target = redirect_i.mtvec;
        end
    end

    assign ar_hs = ar_valid_q & ar_ready_i;
    // a stale response is drained even when the queue is full
    assign r_ready_o = r_wait_q & (stale_q | ~q_full_i);
    assign r_hs = r_valid_i & r_ready_o;
    assign push_now = r_hs & ~stale_q & ~redirect_hit;

    // new read when nothing is outstanding or the current one just finished
    assign issue = (~ar_valid_q & ~r_wait_q) | r_hs;

    always_comb begin
        if (redirect_hit) begin
            pc_d = target;
        end else if (push_now) begin
            pc_d = pc_q + `FETCH_XLEN'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q       <= `FETCH_RESET_PC;
            ar_valid_q <= 1'b0;
            r_wait_q   <= 1'b0;
            stale_q    <= 1'b0;
            push_q     <= 1'b0;
        end else begin
            pc_q   <= pc_d;
            push_q <= push_now;
            if (issue) begin
                ar_valid_q <= 1'b1;
                r_wait_q   <= 1'b0;
            end else if (ar_hs) begin
                ar_valid_q <= 1'b0;
                r_wait_q   <= 1'b1;
            end
            // old-path read still in flight
            if (r_hs) begin
                stale_q <= 1'b0;
            end else if (redirect_hit && (ar_valid_q || r_wait_q)) begin
                stale_q <= 1'b1;
            end
        end
    end

    // address follows the pc the next read is for
    always_ff @(posedge clk) begin
        if (issue) begin
            ar_addr_q <= {pc_d[`FETCH_XLEN-1:3], 3'b000};
        end
        if (push_now) begin
            q_entry_o.pc   <= pc_q;
            q_entry_o.inst <= pc_q[2] ? r_data_i[63:32] : r_data_i[31:0];
        end
    end

    assign ar_valid_o = ar_valid_q;
    assign ar_addr_o  = ar_addr_q;
    assign q_push_o   = push_q;
    assign q_flush_o  = redirect_hit;

    a_ar_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        q_push_o |-> !q_full_i);

endmodule

//--- inst_queue.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module inst_queue (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  logic                    flush_i,
    input  logic                    pop_i,
    output fetch_pkg::fetch_entry_t head_o,
    output logic                    empty_o,
    output logic                    full_o
);

    fetch_pkg::fetch_entry_t mem [`FETCH_QUEUE_DEPTH];

    logic [`FETCH_QUEUE_AW-1:0] wr_ptr;
    logic [`FETCH_QUEUE_AW-1:0] rd_ptr;
    logic [`FETCH_QUEUE_AW:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == (`FETCH_QUEUE_AW+1)'(`FETCH_QUEUE_DEPTH));

    // flush wins over both ends
    assign do_push = push_i & ~full_o & ~flush_i;
    assign do_pop  = pop_i & ~empty_o & ~flush_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    assign head_o = mem[rd_ptr];

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
        pop_i |-> !empty_o);

    a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        push_i |-> !full_o);

endmodule

//--- inst_predecode.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module inst_predecode (
    input  logic                      clk,
    input  logic                      reset_i,
    input  fetch_pkg::fetch_entry_t   head_i,
    input  logic                      empty_i,
    input  logic                      flush_i,
    output logic                      pop_o,
    input  logic                      stall_i,
    output logic                      dec_valid_o,
    output logic [`FETCH_XLEN-1:0]    dec_pc_o,
    output logic [31:0]               dec_inst_o,
    output rv_inst_pkg::inst_class_e  dec_class_o,
    output logic [`FETCH_XLEN-1:0]    dec_imm_o
);

    rv_inst_pkg::rv_inst_u    inst_v;
    rv_inst_pkg::inst_class_e cls;
    logic [`FETCH_XLEN-1:0]   imm;
    logic [`FETCH_XLEN-1:0]   imm_i;
    logic [`FETCH_XLEN-1:0]   imm_s;
    logic [`FETCH_XLEN-1:0]   imm_b;
    logic [`FETCH_XLEN-1:0]   imm_u;
    logic [`FETCH_XLEN-1:0]   imm_j;
    logic                     dec_valid_q;

    assign inst_v = head_i.inst;

    // sign-extended immediate per format
    assign imm_i = {{(`FETCH_XLEN-12){inst_v.i.imm_11_0[11]}}, inst_v.i.imm_11_0};
    assign imm_s = {{(`FETCH_XLEN-12){inst_v.s.imm_11_5[6]}}, inst_v.s.imm_11_5,
                    inst_v.s.imm_4_0};
    assign imm_b = {{(`FETCH_XLEN-13){inst_v.b.imm_12}}, inst_v.b.imm_12, inst_v.b.imm_11,
                    inst_v.b.imm_10_5, inst_v.b.imm_4_1, 1'b0};
    assign imm_u = {{(`FETCH_XLEN-32){inst_v.u.imm_31_12[19]}}, inst_v.u.imm_31_12, 12'h000};
    assign imm_j = {{(`FETCH_XLEN-21){inst_v.j.imm_20}}, inst_v.j.imm_20,
                    inst_v.j.imm_19_12, inst_v.j.imm_11, inst_v.j.imm_10_1, 1'b0};

    always_comb begin
        case (inst_v.r.opcode)
            rv_inst_pkg::OP_OP:     begin cls = rv_inst_pkg::CLASS_ALU;     imm = '0;    end
            rv_inst_pkg::OP_OPIMM:  begin cls = rv_inst_pkg::CLASS_ALU_IMM; imm = imm_i; end
            rv_inst_pkg::OP_LOAD:   begin cls = rv_inst_pkg::CLASS_LOAD;    imm = imm_i; end
            rv_inst_pkg::OP_STORE:  begin cls = rv_inst_pkg::CLASS_STORE;   imm = imm_s; end
            rv_inst_pkg::OP_BRANCH: begin cls = rv_inst_pkg::CLASS_BRANCH;  imm = imm_b; end
            rv_inst_pkg::OP_JAL:    begin cls = rv_inst_pkg::CLASS_JAL;     imm = imm_j; end
            rv_inst_pkg::OP_JALR:   begin cls = rv_inst_pkg::CLASS_JALR;    imm = imm_i; end
            rv_inst_pkg::OP_LUI:    begin cls = rv_inst_pkg::CLASS_LUI;     imm = imm_u; end
            rv_inst_pkg::OP_AUIPC:  begin cls = rv_inst_pkg::CLASS_AUIPC;   imm = imm_u; end
            // csr number sits in the i-type immediate field
            rv_inst_pkg::OP_SYSTEM: begin cls = rv_inst_pkg::CLASS_SYSTEM;  imm = imm_i; end
            default:                begin cls = rv_inst_pkg::CLASS_ILLEGAL; imm = '0;    end
        endcase
    end

    // refill when the output slot is free or being consumed
    assign pop_o = ~empty_i & ~flush_i & (~dec_valid_q | ~stall_i);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            dec_valid_q <= 1'b0;
        end else if (pop_o) begin
            dec_valid_q <= 1'b1;
        end else if (!stall_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            dec_pc_o    <= head_i.pc;
            dec_inst_o  <= inst_v.raw;
            dec_class_o <= cls;
            dec_imm_o   <= imm;
        end
    end

    assign dec_valid_o = dec_valid_q;

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  fetch_pkg::redirect_t     redirect_i,
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    output logic [`FETCH_XLEN-1:0]   ar_addr_o,
    input  logic                     r_valid_i,
    output logic                     r_ready_o,
    input  logic [`FETCH_XLEN-1:0]   r_data_i,
    input  logic                     stall_i,
    output logic                     dec_valid_o,
    output logic [`FETCH_XLEN-1:0]   dec_pc_o,
    output logic [31:0]              dec_inst_o,
    output rv_inst_pkg::inst_class_e dec_class_o,
    output logic [`FETCH_XLEN-1:0]   dec_imm_o
);

    fetch_pkg::fetch_entry_t q_entry;
    fetch_pkg::fetch_entry_t q_head;
    logic                    q_push;
    logic                    q_flush;
    logic                    q_pop;
    logic                    q_full;
    logic                    q_empty;

    pc_fetch u_pc_fetch (
        .clk        (clk),
        .reset_i    (reset_i),
        .redirect_i (redirect_i),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i),
        .q_full_i   (q_full),
        .q_push_o   (q_push),
        .q_entry_o  (q_entry),
        .q_flush_o  (q_flush)
    );

    inst_queue u_inst_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (q_push),
        .entry_i (q_entry),
        .flush_i (q_flush),
        .pop_i   (q_pop),
        .head_o  (q_head),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

    inst_predecode u_inst_predecode (
        .clk         (clk),
        .reset_i     (reset_i),
        .head_i      (q_head),
        .empty_i     (q_empty),
        .flush_i     (q_flush),
        .pop_o       (q_pop),
        .stall_i     (stall_i),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_inst_o  (dec_inst_o),
        .dec_class_o (dec_class_o),
        .dec_imm_o   (dec_imm_o)
    );

endmodule

//--- tb_imem.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_imem (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  logic [`FETCH_XLEN-1:0] ar_addr_i,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output logic [`FETCH_XLEN-1:0] r_data_o,
    output int                     errors_o
);

    // memory words keyed by 8-byte aligned address, filled on first use
    logic [63:0] mem_words [logic [63:0]];

    // mostly valid opcodes so that every format shows up
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 12)
            0:       w[6:0] = rv_inst_pkg::OP_LOAD;
            1:       w[6:0] = rv_inst_pkg::OP_STORE;
            2:       w[6:0] = rv_inst_pkg::OP_BRANCH;
            3:       w[6:0] = rv_inst_pkg::OP_JAL;
            4:       w[6:0] = rv_inst_pkg::OP_JALR;
            5:       w[6:0] = rv_inst_pkg::OP_OPIMM;
            6:       w[6:0] = rv_inst_pkg::OP_OP;
            7:       w[6:0] = rv_inst_pkg::OP_LUI;
            8:       w[6:0] = rv_inst_pkg::OP_AUIPC;
            9:       w[6:0] = rv_inst_pkg::OP_SYSTEM;
            default: w[6:0] = w[6:0];
        endcase
        return w;
    endfunction

    function automatic logic [63:0] word_at(input logic [63:0] addr);
        if (!mem_words.exists(addr)) begin
            mem_words[addr] = {random_inst(), random_inst()};
        end
        return mem_words[addr];
    endfunction

    initial begin
        int unsigned i;
        int unsigned delay;
        logic [63:0] addr;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        errors_o   = 0;
        i = 0;
        while (reset_i !== 1'b0 && i < 1000) begin
            @(negedge clk);
            i++;
        end
        forever begin
            // address phase
            i = 0;
            while (!ar_valid_i && i < 1000) begin
                @(negedge clk);
                i++;
            end
            if (!ar_valid_i) begin
                $display("No read address was issued within 1000 cycles");
                errors_o++;
                continue;
            end
            addr = ar_addr_i;
            if (addr[2:0] != 3'b000) begin
                $display("Error read_channel align: expected %h, actual %h",
                         {addr[63:3], 3'b000}, addr);
                errors_o++;
            end
            delay = $urandom % 4;
            repeat (delay) begin
                @(negedge clk);
                if (!ar_valid_i || ar_addr_i != addr) begin
                    $display("Error read_channel addr_hold: expected %h, actual %h",
                             addr, ar_addr_i);
                    errors_o++;
                end
            end
            ar_ready_o = 1'b1;
            @(negedge clk);
            ar_ready_o = 1'b0;
            // data phase, no new address allowed until it ends
            delay = $urandom % 5;
            repeat (delay) begin
                if (ar_valid_i) begin
                    $display("Second read address %h issued before data of %h", ar_addr_i, addr);
                    errors_o++;
                end
                @(negedge clk);
            end
            r_valid_o = 1'b1;
            r_data_o  = word_at(addr);
            i = 0;
            while (!r_ready_i && i < 2000) begin
                if (ar_valid_i) begin
                    $display("Second read address %h issued before data of %h", ar_addr_i, addr);
                    errors_o++;
                end
                @(negedge clk);
                i++;
            end
            if (!r_ready_i) begin
                $display("Read data for %h was not accepted within 2000 cycles", addr);
                errors_o++;
            end
            @(negedge clk);
            r_valid_o = 1'b0;
        end
    end

endmodule

//--- tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch;

    logic                     clk;
    logic                     reset_i;
    fetch_pkg::redirect_t     redirect_i;
    logic                     ar_valid;
    logic                     ar_ready;
    logic [`FETCH_XLEN-1:0]   ar_addr;
    logic                     r_valid;
    logic                     r_ready;
    logic [`FETCH_XLEN-1:0]   r_data;
    logic                     stall_i;
    logic                     dec_valid_o;
    logic [`FETCH_XLEN-1:0]   dec_pc_o;
    logic [31:0]              dec_inst_o;
    rv_inst_pkg::inst_class_e dec_class_o;
    logic [`FETCH_XLEN-1:0]   dec_imm_o;
    int                       mem_errors;

    int                       errors;
    int                       consumed;
    int                       redirects_hit;
    bit                       timed_out;
    bit                       after_redirect;
    bit                       hold_pending;
    string                    test_name;
    logic [63:0]              exp_pc;
    logic [63:0]              held_pc;
    logic [63:0]              held_imm;
    logic [31:0]              held_inst;
    rv_inst_pkg::inst_class_e held_class;

    fetch_top uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .redirect_i  (redirect_i),
        .ar_valid_o  (ar_valid),
        .ar_ready_i  (ar_ready),
        .ar_addr_o   (ar_addr),
        .r_valid_i   (r_valid),
        .r_ready_o   (r_ready),
        .r_data_i    (r_data),
        .stall_i     (stall_i),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_inst_o  (dec_inst_o),
        .dec_class_o (dec_class_o),
        .dec_imm_o   (dec_imm_o)
    );

    tb_imem u_imem (
        .clk        (clk),
        .reset_i    (reset_i),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .errors_o   (mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    // reference decode straight from the instruction bit layout
    function automatic void model_decode(input logic [31:0] w,
                                         output rv_inst_pkg::inst_class_e cls,
                                         output logic [63:0] imm);
        logic [63:0] i_imm;
        logic [63:0] s_imm;
        logic [63:0] b_imm;
        logic [63:0] u_imm;
        logic [63:0] j_imm;
        i_imm = {{52{w[31]}}, w[31:20]};
        s_imm = {{52{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {{32{w[31]}}, w[31:12], 12'h000};
        j_imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        cls = rv_inst_pkg::CLASS_ILLEGAL;
        imm = '0;
        case (w[6:0])
            rv_inst_pkg::OP_OP:     cls = rv_inst_pkg::CLASS_ALU;
            rv_inst_pkg::OP_OPIMM:  begin cls = rv_inst_pkg::CLASS_ALU_IMM; imm = i_imm; end
            rv_inst_pkg::OP_LOAD:   begin cls = rv_inst_pkg::CLASS_LOAD;    imm = i_imm; end
            rv_inst_pkg::OP_STORE:  begin cls = rv_inst_pkg::CLASS_STORE;   imm = s_imm; end
            rv_inst_pkg::OP_BRANCH: begin cls = rv_inst_pkg::CLASS_BRANCH;  imm = b_imm; end
            rv_inst_pkg::OP_JAL:    begin cls = rv_inst_pkg::CLASS_JAL;     imm = j_imm; end
            rv_inst_pkg::OP_JALR:   begin cls = rv_inst_pkg::CLASS_JALR;    imm = i_imm; end
            rv_inst_pkg::OP_LUI:    begin cls = rv_inst_pkg::CLASS_LUI;     imm = u_imm; end
            rv_inst_pkg::OP_AUIPC:  begin cls = rv_inst_pkg::CLASS_AUIPC;   imm = u_imm; end
            rv_inst_pkg::OP_SYSTEM: begin cls = rv_inst_pkg::CLASS_SYSTEM;  imm = i_imm; end
            default:                cls = rv_inst_pkg::CLASS_ILLEGAL;
        endcase
    endfunction

    // one kind or a pair, targets stay 4-byte aligned
    function automatic fetch_pkg::redirect_t make_redirect();
        fetch_pkg::redirect_t r;
        logic [31:0]          off;
        r = '0;
        off = 32'(int'($urandom % 2048) - 1024) << 2;
        r.imm      = {{32{off[31]}}, off};
        r.base_pc  = 64'h8000_0000 + 64'($urandom & 32'h0000_fffc);
        r.rs1_data = 64'h8000_0000 + 64'($urandom & 32'h0000_fffd);
        r.mtvec    = 64'h8000_0000 + 64'($urandom & 32'h0000_fffc);
        case ($urandom % 7)
            0: r.jal = 1'b1;
            1: r.branch_taken = 1'b1;
            2: r.jalr = 1'b1;
            3: r.trap = 1'b1;
            4: begin r.jal = 1'b1; r.trap = 1'b1; end
            5: begin r.jalr = 1'b1; r.trap = 1'b1; end
            default: begin r.branch_taken = 1'b1; r.jalr = 1'b1; end
        endcase
        return r;
    endfunction

    function automatic logic [63:0] redirect_target(input fetch_pkg::redirect_t r);
        logic [63:0] t;
        if (r.jal || r.branch_taken) begin
            t = r.base_pc + r.imm;
        end else if (r.jalr) begin
            t = r.rs1_data + r.imm;
            t[0] = 1'b0;
        end else begin
            t = r.mtvec;
        end
        return t;
    endfunction

    // the instruction on the dec_ outputs is taken at the coming edge
    task automatic check_output();
        logic [63:0]              word;
        logic [31:0]              exp_inst;
        rv_inst_pkg::inst_class_e exp_class;
        logic [63:0]              exp_imm;
        word = u_imem.word_at({exp_pc[63:3], 3'b000});
        exp_inst = exp_pc[2] ? word[63:32] : word[31:0];
        model_decode(exp_inst, exp_class, exp_imm);
        if (dec_pc_o != exp_pc) begin
            report_mismatch("pc", exp_pc, dec_pc_o);
        end else if (after_redirect) begin
            redirects_hit++;
        end
        if (dec_inst_o != exp_inst) begin
            report_mismatch("inst", 64'(exp_inst), 64'(dec_inst_o));
        end
        if (dec_class_o != exp_class) begin
            report_mismatch("class", 64'(exp_class), 64'(dec_class_o));
        end
        if (dec_imm_o != exp_imm) begin
            report_mismatch("imm", exp_imm, dec_imm_o);
        end
        after_redirect = 1'b0;
        exp_pc = exp_pc + 64'd4;
        consumed++;
    endtask

    task automatic step_cycle(input int stall_pct, input int redir_pct);
        fetch_pkg::redirect_t r;
        logic                 stall_next;
        logic                 hit;
        @(negedge clk);
        if (hold_pending) begin
            if (!dec_valid_o || dec_pc_o != held_pc || dec_inst_o != held_inst ||
                dec_class_o != held_class || dec_imm_o != held_imm) begin
                $display("Error %s hold: expected pc %h inst %h, actual pc %h inst %h valid %b",
                         test_name, held_pc, held_inst, dec_pc_o, dec_inst_o, dec_valid_o);
                errors++;
            end
        end
        stall_next = (($urandom % 100) < stall_pct);
        r = '0;
        if (($urandom % 100) < redir_pct) begin
            r = make_redirect();
        end
        stall_i    = stall_next;
        redirect_i = r;
        hit = r.jal | r.branch_taken | r.jalr | r.trap;
        if (dec_valid_o && !stall_next) begin
            check_output();
        end
        hold_pending = dec_valid_o && stall_next && !hit;
        held_pc    = dec_pc_o;
        held_inst  = dec_inst_o;
        held_class = dec_class_o;
        held_imm   = dec_imm_o;
        if (hit) begin
            exp_pc = redirect_target(r);
            after_redirect = 1'b1;
        end
    endtask

    task automatic run_until(input int target, input int max_cycles, input int stall_pct,
                             input int redir_pct);
        int n;
        n = 0;
        while (consumed < target && n < max_cycles) begin
            step_cycle(stall_pct, redir_pct);
            n++;
        end
        if (consumed < target) begin
            $display("Timeout in %s: %0d of %0d instructions decoded after %0d cycles",
                     test_name, consumed, target, n);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'hbe54));
        reset_i        = 1'b1;
        stall_i        = 1'b0;
        redirect_i     = '0;
        errors         = 0;
        consumed       = 0;
        redirects_hit  = 0;
        timed_out      = 1'b0;
        after_redirect = 1'b0;
        hold_pending   = 1'b0;
        exp_pc         = `FETCH_RESET_PC;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;

        test_name = "sequential";
        run_until(40, 2000, 30, 0);
        if (!timed_out) begin
            // long stall lets the queue fill up
            test_name = "long_stall";
            repeat (50) step_cycle(100, 0);
            run_until(consumed + 20, 2000, 0, 0);
        end
        if (!timed_out) begin
            test_name = "redirect";
            run_until(consumed + 300, 40000, 35, 3);
        end
        if (!timed_out && redirects_hit == 0) begin
            $display("No instruction was decoded at a redirect target");
            errors++;
        end

        $display("decoded %0d, redirect targets %0d, errors %0d, memory errors %0d",
                 consumed, redirects_hit, errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
fetch_pkg.sv
rv_inst_pkg.sv
pc_fetch.sv
inst_queue.sv
inst_predecode.sv
fetch_top.sv
tb_imem.sv
tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_fetch -o tb_fetch_sim

./obj_dir/tb_fetch_sim > sim.log 2>&1

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
